// ==== mult_sizes_pkg.sv ====
`default_nettype none

package mult_sizes_pkg;

	// ----------------------------------------------
	// Array geometry
	// ----------------------------------------------

	localparam int OPERAND_WIDTH = 16;
	localparam int PRODUCT_WIDTH = 2 * OPERAND_WIDTH;

	// One registered row per multiplier bit after bit 0.
	localparam int ROW_COUNT = OPERAND_WIDTH - 1;

	// ----------------------------------------------
	// Data types
	// ----------------------------------------------

	typedef logic [OPERAND_WIDTH-1:0] operand_t;
	typedef logic [PRODUCT_WIDTH-1:0] product_t;

endpackage

`default_nettype wire

// ==== adder_cell_pkg.sv ====
`default_nettype none

package adder_cell_pkg;

	// ----------------------------------------------
	// Bit cells returning {carry, sum}
	// ----------------------------------------------

	function automatic logic [1:0] half_add(
		input logic a,
		input logic b
	);
		logic s;
		logic c;
		s = a ^ b;
		c = a & b;
		return {c, s};
	endfunction

	function automatic logic [1:0] full_add(
		input logic a,
		input logic b,
		input logic cin
	);
		logic s;
		logic c;
		s = a ^ b ^ cin;
		c = (a & b) | (cin & (a ^ b)); // Generate or propagate.
		return {c, s};
	endfunction

endpackage

`default_nettype wire

// ==== operand_stage.sv ====
`default_nettype none

module operand_stage (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     in_valid,
	input  mult_sizes_pkg::operand_t x,
	input  mult_sizes_pkg::operand_t y,
	output logic                     stage_valid,
	output mult_sizes_pkg::operand_t x_out,
	output mult_sizes_pkg::operand_t y_rest,
	output mult_sizes_pkg::operand_t sum_row,
	output mult_sizes_pkg::operand_t carry_row,
	output mult_sizes_pkg::operand_t low_bits
);

	import mult_sizes_pkg::*;

	operand_t pp_row;

	// Row 0 of the array.
	assign pp_row = x & {OPERAND_WIDTH{y[0]}};

	// No carries exist before the first addition.
	assign carry_row = '0;

	// ----------------------------------------------
	// Valid pipeline
	// ----------------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			stage_valid <= 1'b0;
		end else begin
			stage_valid <= in_valid;
		end
	end

	// ----------------------------------------------
	// Operand and first row registers
	// ----------------------------------------------

	always_ff @(posedge clk) begin
		x_out   <= x;
		y_rest  <= y >> 1;        // Next row sees bit 1 at bit 0.
		sum_row <= pp_row;
		// Bit 0 of row 0 is already a final product bit.
		low_bits <= {pp_row[0], {(OPERAND_WIDTH-1){1'b0}}};
	end

endmodule

`default_nettype wire

// ==== csa_row_stage.sv ====
`default_nettype none

module csa_row_stage (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     in_valid,
	input  mult_sizes_pkg::operand_t x_in,
	input  mult_sizes_pkg::operand_t y_in,
	input  mult_sizes_pkg::operand_t sum_in,
	input  mult_sizes_pkg::operand_t carry_in,
	input  mult_sizes_pkg::operand_t low_in,
	output logic                     out_valid,
	output mult_sizes_pkg::operand_t x_out,
	output mult_sizes_pkg::operand_t y_out,
	output mult_sizes_pkg::operand_t sum_out,
	output mult_sizes_pkg::operand_t carry_out,
	output mult_sizes_pkg::operand_t low_out
);

	import mult_sizes_pkg::*;
	import adder_cell_pkg::*;

	operand_t pp_row;
	operand_t sum_up;
	operand_t sum_next;
	operand_t carry_next;

	// ----------------------------------------------
	// Carry-save addition of one row
	// ----------------------------------------------

	assign pp_row = x_in & {OPERAND_WIDTH{y_in[0]}};

	// Previous sums move down one column and a zero enters at the top.
	assign sum_up = {1'b0, sum_in[OPERAND_WIDTH-1:1]};

	// The top column sees a zero sum and a zero carry, so it passes the
	// row's top bit through as its sum.
	always_comb begin
		for (int j = 0; j < OPERAND_WIDTH; j++) begin
			{carry_next[j], sum_next[j]} = full_add(pp_row[j], sum_up[j], carry_in[j]);
		end
	end

	// ----------------------------------------------
	// Stage registers
	// ----------------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		x_out     <= x_in;
		y_out     <= y_in >> 1;                                   // Consume one multiplier bit.
		sum_out   <= sum_next;
		carry_out <= carry_next;
		low_out   <= {sum_next[0], low_in[OPERAND_WIDTH-1:1]}; // Retire one product bit.
	end

endmodule

`default_nettype wire

// ==== carry_propagate_stage.sv ====
`default_nettype none

module carry_propagate_stage (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     in_valid,
	input  mult_sizes_pkg::operand_t sum_in,
	input  mult_sizes_pkg::operand_t carry_in,
	input  mult_sizes_pkg::operand_t low_in,
	output logic                     product_valid,
	output mult_sizes_pkg::product_t product
);

	import mult_sizes_pkg::*;
	import adder_cell_pkg::*;

	operand_t                 upper;
	logic [OPERAND_WIDTH-2:0] chain;

	// ----------------------------------------------
	// Ripple addition of the upper half
	// ----------------------------------------------

	always_comb begin
		{chain[0], upper[0]} = half_add(carry_in[0], sum_in[1]);
		for (int j = 1; j < OPERAND_WIDTH - 1; j++) begin
			{chain[j], upper[j]} = full_add(carry_in[j], sum_in[j+1], chain[j-1]);
		end
		upper[OPERAND_WIDTH-1] = chain[OPERAND_WIDTH-2]; // Final carry is the MSB.
	end

	// ----------------------------------------------
	// Output registers
	// ----------------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			product_valid <= 1'b0;
		end else begin
			product_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		product <= {upper, low_in};
	end

endmodule

`default_nettype wire

// ==== array_multiplier.sv ====
`default_nettype none

module array_multiplier (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     in_valid,
	input  mult_sizes_pkg::operand_t x,
	input  mult_sizes_pkg::operand_t y,
	output logic                     product_valid,
	output mult_sizes_pkg::product_t product
);

	import mult_sizes_pkg::*;

	// Element 0 comes from the operand stage, element i+1 from row i.
	logic     stage_valid [0:ROW_COUNT];
	operand_t x_pipe      [0:ROW_COUNT];
	operand_t y_rest      [0:ROW_COUNT];
	operand_t sum_row     [0:ROW_COUNT];
	operand_t carry_row   [0:ROW_COUNT];
	operand_t low_bits    [0:ROW_COUNT];

	operand_stage operand_stage_i (
		.clk         (clk),
		.reset       (reset),
		.in_valid    (in_valid),
		.x           (x),
		.y           (y),
		.stage_valid (stage_valid[0]),
		.x_out       (x_pipe[0]),
		.y_rest      (y_rest[0]),
		.sum_row     (sum_row[0]),
		.carry_row   (carry_row[0]),
		.low_bits    (low_bits[0])
	);

	// ----------------------------------------------
	// Carry-save array of registered rows
	// ----------------------------------------------

	for (genvar i = 0; i < ROW_COUNT; i++) begin : row_g
		csa_row_stage row_i (
			.clk       (clk),
			.reset     (reset),
			.in_valid  (stage_valid[i]),
			.x_in      (x_pipe[i]),
			.y_in      (y_rest[i]),
			.sum_in    (sum_row[i]),
			.carry_in  (carry_row[i]),
			.low_in    (low_bits[i]),
			.out_valid (stage_valid[i+1]),
			.x_out     (x_pipe[i+1]),
			.y_out     (y_rest[i+1]),
			.sum_out   (sum_row[i+1]),
			.carry_out (carry_row[i+1]),
			.low_out   (low_bits[i+1])
		);
	end

	carry_propagate_stage carry_propagate_stage_i (
		.clk           (clk),
		.reset         (reset),
		.in_valid      (stage_valid[ROW_COUNT]),
		.sum_in        (sum_row[ROW_COUNT]),
		.carry_in      (carry_row[ROW_COUNT]),
		.low_in        (low_bits[ROW_COUNT]),
		.product_valid (product_valid),
		.product       (product)
	);

endmodule

`default_nettype wire

// ==== tb_array_multiplier.sv ====
`default_nettype none

module tb_array_multiplier;

	import mult_sizes_pkg::*;

	localparam logic [31:0] SEED = 32'h3e6d_540d;
	localparam int LATENCY    = 17;
	localparam int CORNER_OPS = 10;
	localparam int BURST_OPS  = 500;
	localparam int GAP_OPS    = 200;
	localparam int MAX_GAP    = 3;
	localparam int RESET_OPS  = 40;
	localparam int TEST_COUNT = 4;
	// Issue cycles when every gap is at its longest.
	localparam int ISSUE_SLOTS = CORNER_OPS + BURST_OPS + GAP_OPS * (MAX_GAP + 1)
		+ 2 * RESET_OPS;
	localparam int WATCHDOG_LIMIT = (ISSUE_SLOTS + LATENCY * TEST_COUNT + 50) * 10;

	typedef struct packed {
		operand_t x;
		operand_t y;
		product_t product;
		int       issue; // Edge that sampled in_valid.
	} expect_t;

	logic     clk;
	logic     reset;
	logic     in_valid;
	operand_t x;
	operand_t y;
	logic     product_valid;
	product_t product;

	expect_t     expect_q [$];
	logic [31:0] lcg_state;
	int          cycle_count = 0;
	logic        reset_q = 1'b1;
	int          compare_errors = 0;
	int          driver_errors = 0;
	int          issued_count = 0;
	int          received_count = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          test_start_errors = 0;

	array_multiplier dut_i (
		.clk           (clk),
		.reset         (reset),
		.in_valid      (in_valid),
		.x             (x),
		.y             (y),
		.product_valid (product_valid),
		.product       (product)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		reset_q     <= reset;
	end

	// ----------------------------------------------
	// Stimulus helpers
	// ----------------------------------------------

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Plain 32-bit product of zero-extended operands.
	function automatic product_t reference_product(input operand_t a, input operand_t b);
		product_t wide_a;
		product_t wide_b;
		wide_a = {{OPERAND_WIDTH{1'b0}}, a};
		wide_b = {{OPERAND_WIDTH{1'b0}}, b};
		return wide_a * wide_b;
	endfunction

	task automatic issue_op(input operand_t a, input operand_t b);
		expect_t item;
		item.x       = a;
		item.y       = b;
		item.product = reference_product(a, b);
		item.issue   = cycle_count + 1;
		in_valid = 1'b1;
		x        = a;
		y        = b;
		expect_q.push_back(item);
		issued_count++;
		@(posedge clk);
		#1;
	endtask

	task automatic issue_random();
		logic [31:0] rnd_x;
		logic [31:0] rnd_y;
		rnd_x = next_random();
		rnd_y = next_random();
		issue_op(rnd_x[31:16], rnd_y[31:16]); // Upper LCG bits are the better ones.
	endtask

	task automatic idle_cycles(input int count);
		in_valid = 1'b0;
		repeat (count) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic reset_midstream();
		in_valid = 1'b0;
		reset    = 1'b1;
		@(posedge clk);
		#1;
		// Everything still in the pipeline is discarded.
		expect_q.delete();
		issued_count = received_count;
		@(posedge clk);
		#1;
		reset = 1'b0;
	endtask

	task automatic finish_test(input string name, input int quiet_cycles);
		int test_errors;
		in_valid = 1'b0;
		while (expect_q.size() != 0) begin
			@(posedge clk);
			#1;
		end
		idle_cycles(quiet_cycles);
		if (received_count != issued_count) begin
			$display("Test %0s issued %0d operations but saw %0d products", name,
				issued_count, received_count);
			driver_errors++;
		end
		test_errors = compare_errors + driver_errors - test_start_errors;
		tests_run++;
		if (test_errors != 0) begin
			tests_failed++;
			$display("Test %0s: FAIL with %0d errors", name, test_errors);
		end else begin
			$display("Test %0s: pass", name);
		end
		test_start_errors = compare_errors + driver_errors;
	endtask

	// ----------------------------------------------
	// Output comparison
	// ----------------------------------------------

	always @(negedge clk) begin : compare_outputs
		expect_t item;
		int      latency;
		if (reset_q) begin
			if (product_valid === 1'b1) begin
				$display("product_valid is high at %0t while the pipeline is in reset", $time);
				compare_errors++;
			end
		end else if (product_valid === 1'b1) begin
			received_count++;
			if (expect_q.size() == 0) begin
				$display("Unexpected product %h at %0t with no operation in flight",
					product, $time);
				compare_errors++;
			end else begin
				item    = expect_q.pop_front();
				latency = cycle_count + 1 - item.issue; // Edge that would sample it.
				if (product !== item.product) begin
					$display("Error at %0t: %h x %h gave %h, expected %h", $time,
						item.x, item.y, product, item.product);
					compare_errors++;
				end
				if (latency != LATENCY) begin
					$display("Error at %0t: product came %0d cycles after issue, expected %0d",
						$time, latency, LATENCY);
					compare_errors++;
				end
			end
		end else if (product_valid !== 1'b0) begin
			$display("product_valid is unknown at %0t", $time);
			compare_errors++;
		end
	end

	initial begin
		#(WATCHDOG_LIMIT);
		$display("Timeout: the tests did not finish within %0d time units", WATCHDOG_LIMIT);
		$display("ERRORS FOUND");
		$finish;
	end

	// ----------------------------------------------
	// Test sequence
	// ----------------------------------------------

	initial begin : run_tests
		int          gap;
		logic [31:0] rnd;
		in_valid  = 1'b0;
		x         = '0;
		y         = '0;
		reset     = 1'b1;
		lcg_state = SEED;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;

		issue_op(16'h0000, 16'h1234);
		issue_op(16'h5a5a, 16'h0000);
		issue_op(16'h0001, 16'hbeef);
		issue_op(16'hc0de, 16'h0001);
		issue_op(16'hffff, 16'h0001);
		issue_op(16'h0001, 16'hffff);
		issue_op(16'hffff, 16'hffff); // Every column carries.
		issue_op(16'h8000, 16'h8000);
		issue_op(16'hffff, 16'h0000);
		issue_op(16'h0001, 16'h0001);
		finish_test("corner operands", 0);

		for (int i = 0; i < BURST_OPS; i++) begin
			issue_random();
		end
		finish_test("back-to-back random", 0);

		for (int i = 0; i < GAP_OPS; i++) begin
			rnd = next_random();
			gap = int'(rnd[31:16]) % (MAX_GAP + 1);
			idle_cycles(gap);
			issue_random();
		end
		finish_test("random idle gaps", 8);

		for (int i = 0; i < RESET_OPS; i++) begin
			issue_random();
		end
		reset_midstream();
		for (int i = 0; i < RESET_OPS; i++) begin
			issue_random();
		end
		finish_test("reset mid-stream", 0);

		$display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
			compare_errors + driver_errors);
		if (compare_errors + driver_errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
mult_sizes_pkg.sv
adder_cell_pkg.sv
operand_stage.sv
csa_row_stage.sv
carry_propagate_stage.sv
array_multiplier.sv
tb_array_multiplier.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the array multiplier testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

TOP=tb_array_multiplier
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -f vlog.f --top-module "$TOP" -Mdir "$BUILD_DIR" -o "$TOP"
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
	echo "Simulation reported failures, see $LOG"
	exit 1
fi

echo "Simulation passed"
exit 0
